//--- logic/pinmux_pkg.sv
// Peripheral register map definitions
`default_nettype none

package pinmux_pkg;

   // --------------------------------------------------------------------
   // Bus widths
   // --------------------------------------------------------------------
   localparam int ADDR_W    = 9;
   localparam int DATA_W    = 32;
   localparam int BE_W      = 4;

   // Block select lives in addr[8:6]
   localparam int BLK_SEL_W = 3;
   localparam logic [BLK_SEL_W-1:0] SEL_GPIO  = 3'b001;
   localparam logic [BLK_SEL_W-1:0] SEL_PWM   = 3'b010;
   localparam logic [BLK_SEL_W-1:0] SEL_TIMER = 3'b011;

   // Word offset inside a block, addr[5:2]
   localparam int OFS_W = 4;

   // --------------------------------------------------------------------
   // Register offsets and field widths
   // --------------------------------------------------------------------
   localparam logic [OFS_W-1:0] GPIO_OFS_DIR  = 4'd0;
   localparam logic [OFS_W-1:0] GPIO_OFS_OUT  = 4'd1;
   localparam logic [OFS_W-1:0] GPIO_OFS_IN   = 4'd2;
   localparam logic [OFS_W-1:0] GPIO_OFS_FUNC = 4'd3;

   // Timer i config at offset i, status above them
   localparam logic [OFS_W-1:0] TMR_OFS_STATUS = 4'd4;

   localparam int PWM_CNT_W = 8;
   localparam int TMR_CNT_W = 16;

   // Byte lane merge for partial writes
   function automatic logic [DATA_W-1:0] apply_be(input logic [DATA_W-1:0] old_v,
                                                  input logic [DATA_W-1:0] new_v,
                                                  input logic [BE_W-1:0]   be);
      logic [DATA_W-1:0] res;
      for (int b = 0; b < BE_W; b++) begin
         res[8*b +: 8] = be[b] ? new_v[8*b +: 8] : old_v[8*b +: 8];
      end
      return res;
   endfunction

endpackage

`default_nettype wire

//--- logic/reg_decode.sv
// Register bus block decoder
`timescale 1ns/1ps
`default_nettype none

module reg_decode (
   input  wire logic                           reg_cs_i,
   input  wire logic [pinmux_pkg::ADDR_W-1:0]  reg_addr_i,
   input  wire logic [pinmux_pkg::DATA_W-1:0]  gpio_rdata_i,
   input  wire logic [pinmux_pkg::DATA_W-1:0]  pwm_rdata_i,
   input  wire logic [pinmux_pkg::DATA_W-1:0]  tmr_rdata_i,
   input  wire logic                           gpio_ack_i,
   input  wire logic                           pwm_ack_i,
   input  wire logic                           tmr_ack_i,
   output logic                                gpio_cs_o,
   output logic                                pwm_cs_o,
   output logic                                tmr_cs_o,
   output logic [pinmux_pkg::DATA_W-1:0]       reg_rdata_o,
   output logic                                reg_ack_o
);
   import pinmux_pkg::*;

   logic [BLK_SEL_W-1:0] blk_sel;

   // Top address bits pick the block
   assign blk_sel = reg_addr_i[ADDR_W-1 -: BLK_SEL_W];

   // --------------------------------------------------------------------
   // Chip select steering
   // --------------------------------------------------------------------
   assign gpio_cs_o = reg_cs_i & (blk_sel == SEL_GPIO);
   assign pwm_cs_o  = reg_cs_i & (blk_sel == SEL_PWM);
   assign tmr_cs_o  = reg_cs_i & (blk_sel == SEL_TIMER);

   // --------------------------------------------------------------------
   // Return path
   // --------------------------------------------------------------------
   always_comb begin
      case (blk_sel)
         SEL_GPIO: begin
            reg_rdata_o = gpio_rdata_i;
            reg_ack_o   = gpio_ack_i;
         end
         SEL_PWM: begin
            reg_rdata_o = pwm_rdata_i;
            reg_ack_o   = pwm_ack_i;
         end
         SEL_TIMER: begin
            reg_rdata_o = tmr_rdata_i;
            reg_ack_o   = tmr_ack_i;
         end
         // Unmapped space, master times out
         default: begin
            reg_rdata_o = '0;
            reg_ack_o   = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/tick_gen.sv
// Slow tick pulse generator
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
   parameter int TICK_DIV = 50000
) (
   input  wire logic mclk,
   input  wire logic rst_n_i,
   output logic      tick_o
);

   // Guard against a divide of one
   localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(TICK_DIV - 1);

   logic [CNT_W-1:0] cnt_q;
   logic             wrap;

   // Last count of the period
   assign wrap = (cnt_q == CNT_MAX);

   // Free running divider
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (wrap) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // One mclk wide pulse per period
   assign tick_o = wrap;

endmodule

`default_nettype wire

//--- logic/timer_bank.sv
// Tick driven down-counting timers
`timescale 1ns/1ps
`default_nettype none

module timer_bank #(
   parameter int NUM_TIMERS = 3
) (
   input  wire logic                          mclk,
   input  wire logic                          rst_n_i,
   input  wire logic                          reg_cs_i,
   input  wire logic                          reg_wr_i,
   input  wire logic [pinmux_pkg::OFS_W-1:0]  reg_ofs_i,
   input  wire logic [pinmux_pkg::DATA_W-1:0] reg_wdata_i,
   input  wire logic [pinmux_pkg::BE_W-1:0]   reg_be_i,
   input  wire logic                          tick_i,
   output logic [pinmux_pkg::DATA_W-1:0]      reg_rdata_o,
   output logic                               reg_ack_o,
   output logic [NUM_TIMERS-1:0]              timer_irq_o
);
   import pinmux_pkg::*;

   logic                                 ack_q;
   logic [DATA_W-1:0]                    rdata_q;
   logic [DATA_W-1:0]                    rdata_d;
   logic                                 wr_en;
   logic [NUM_TIMERS-1:0]                en_q;
   logic [NUM_TIMERS-1:0][TMR_CNT_W-1:0] load_q;
   logic [NUM_TIMERS-1:0][TMR_CNT_W-1:0] cnt_q;
   logic [NUM_TIMERS-1:0][DATA_W-1:0]    cfg_cur;
   logic [NUM_TIMERS-1:0][DATA_W-1:0]    cfg_new;
   logic [NUM_TIMERS-1:0]                cfg_we;
   logic [NUM_TIMERS-1:0]                status_q;
   logic [NUM_TIMERS-1:0]                status_set;
   logic [NUM_TIMERS-1:0]                status_clr;

   // --------------------------------------------------------------------
   // Bus handshake
   // --------------------------------------------------------------------
   // Single write strobe per access
   assign wr_en = reg_cs_i & reg_wr_i & ~ack_q;

   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= reg_cs_i & ~ack_q;
      end
   end

   // Read data held for the ack cycle
   always_ff @(posedge mclk) begin
      if (reg_cs_i && !ack_q) begin
         rdata_q <= rdata_d;
      end
   end

   assign reg_ack_o   = ack_q;
   assign reg_rdata_o = rdata_q;

   // --------------------------------------------------------------------
   // Config view, write decode and expiry
   // --------------------------------------------------------------------
   always_comb begin
      rdata_d = '0;
      for (int i = 0; i < NUM_TIMERS; i++) begin
         // Enable sits right above the load field
         cfg_cur[i] = '0;
         cfg_cur[i][TMR_CNT_W] = en_q[i];
         cfg_cur[i][TMR_CNT_W-1:0] = load_q[i];
         cfg_new[i] = apply_be(cfg_cur[i], reg_wdata_i, reg_be_i);
         cfg_we[i] = wr_en && (reg_ofs_i == OFS_W'(i));
         // Tick at zero count ends the period
         status_set[i] = en_q[i] && tick_i && !cfg_we[i] && (cnt_q[i] == '0);
         if (reg_ofs_i == OFS_W'(i)) begin
            rdata_d = cfg_cur[i];
         end
      end
      if (reg_ofs_i == TMR_OFS_STATUS) begin
         rdata_d[NUM_TIMERS-1:0] = status_q;
      end
   end

   // Write one to clear, low byte only
   assign status_clr = (wr_en && (reg_ofs_i == TMR_OFS_STATUS) && reg_be_i[0]) ?
                       reg_wdata_i[NUM_TIMERS-1:0] : '0;

   // --------------------------------------------------------------------
   // Counters and sticky status
   // --------------------------------------------------------------------
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         en_q     <= '0;
         load_q   <= '0;
         cnt_q    <= '0;
         status_q <= '0;
      end else begin
         for (int i = 0; i < NUM_TIMERS; i++) begin
            if (cfg_we[i]) begin
               // Config write restarts from the new load
               en_q[i]   <= cfg_new[i][TMR_CNT_W];
               load_q[i] <= cfg_new[i][TMR_CNT_W-1:0];
               cnt_q[i]  <= cfg_new[i][TMR_CNT_W-1:0];
            end else if (en_q[i] && tick_i) begin
               cnt_q[i] <= (cnt_q[i] == '0) ? load_q[i] : cnt_q[i] - 1'b1;
            end
         end
         // New expiry beats a same cycle clear
         status_q <= (status_q & ~status_clr) | status_set;
      end
   end

   assign timer_irq_o = status_q;

endmodule

`default_nettype wire

//--- logic/pwm_bank.sv
// Bank of PWM waveform generators
`timescale 1ns/1ps
`default_nettype none

module pwm_bank #(
   parameter int NUM_PWM = 4
) (
   input  wire logic                          mclk,
   input  wire logic                          rst_n_i,
   input  wire logic                          reg_cs_i,
   input  wire logic                          reg_wr_i,
   input  wire logic [pinmux_pkg::OFS_W-1:0]  reg_ofs_i,
   input  wire logic [pinmux_pkg::DATA_W-1:0] reg_wdata_i,
   input  wire logic [pinmux_pkg::BE_W-1:0]   reg_be_i,
   output logic [pinmux_pkg::DATA_W-1:0]      reg_rdata_o,
   output logic                               reg_ack_o,
   output logic [NUM_PWM-1:0]                 pwm_wfm_o
);
   import pinmux_pkg::*;

   // Enable bit after the high and period bytes
   localparam int EN_BIT = 2 * PWM_CNT_W;

   logic                              ack_q;
   logic [DATA_W-1:0]                 rdata_q;
   logic [DATA_W-1:0]                 rdata_d;
   logic                              wr_en;
   logic [NUM_PWM-1:0]                en_q;
   logic [NUM_PWM-1:0][PWM_CNT_W-1:0] high_q;
   logic [NUM_PWM-1:0][PWM_CNT_W-1:0] per_q;
   logic [NUM_PWM-1:0][PWM_CNT_W-1:0] cnt_q;
   logic [NUM_PWM-1:0][DATA_W-1:0]    cfg_cur;
   logic [NUM_PWM-1:0][DATA_W-1:0]    cfg_new;

   // --------------------------------------------------------------------
   // Bus handshake
   // --------------------------------------------------------------------
   assign wr_en = reg_cs_i & reg_wr_i & ~ack_q;

   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= reg_cs_i & ~ack_q;
      end
   end

   always_ff @(posedge mclk) begin
      if (reg_cs_i && !ack_q) begin
         rdata_q <= rdata_d;
      end
   end

   assign reg_ack_o   = ack_q;
   assign reg_rdata_o = rdata_q;

   // Channel config as seen on the bus
   always_comb begin
      rdata_d = '0;
      for (int i = 0; i < NUM_PWM; i++) begin
         cfg_cur[i] = '0;
         cfg_cur[i][EN_BIT] = en_q[i];
         cfg_cur[i][EN_BIT-1:PWM_CNT_W] = per_q[i];
         cfg_cur[i][PWM_CNT_W-1:0] = high_q[i];
         cfg_new[i] = apply_be(cfg_cur[i], reg_wdata_i, reg_be_i);
         if (reg_ofs_i == OFS_W'(i)) begin
            rdata_d = cfg_cur[i];
         end
      end
   end

   // --------------------------------------------------------------------
   // Config registers and channel counters
   // --------------------------------------------------------------------
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         en_q   <= '0;
         high_q <= '0;
         per_q  <= '0;
         cnt_q  <= '0;
      end else begin
         for (int i = 0; i < NUM_PWM; i++) begin
            if (wr_en && (reg_ofs_i == OFS_W'(i))) begin
               en_q[i]   <= cfg_new[i][EN_BIT];
               per_q[i]  <= cfg_new[i][EN_BIT-1:PWM_CNT_W];
               high_q[i] <= cfg_new[i][PWM_CNT_W-1:0];
            end
            // Idle channel parks at zero
            if (!en_q[i]) begin
               cnt_q[i] <= '0;
            end else if (cnt_q[i] >= per_q[i]) begin
               cnt_q[i] <= '0;
            end else begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   // High for the first H counts of each period
   always_comb begin
      for (int i = 0; i < NUM_PWM; i++) begin
         pwm_wfm_o[i] = en_q[i] && (cnt_q[i] < high_q[i]);
      end
   end

endmodule

`default_nettype wire

//--- logic/gpio_pinmux.sv
// GPIO registers and pad multiplexer
`timescale 1ns/1ps
`default_nettype none

module gpio_pinmux #(
   parameter int NUM_PADS = 16,
   parameter int NUM_PWM  = 4
) (
   input  wire logic                          mclk,
   input  wire logic                          rst_n_i,
   input  wire logic                          reg_cs_i,
   input  wire logic                          reg_wr_i,
   input  wire logic [pinmux_pkg::OFS_W-1:0]  reg_ofs_i,
   input  wire logic [pinmux_pkg::DATA_W-1:0] reg_wdata_i,
   input  wire logic [pinmux_pkg::BE_W-1:0]   reg_be_i,
   input  wire logic [NUM_PWM-1:0]            pwm_wfm_i,
   input  wire logic [NUM_PADS-1:0]           pad_in_i,
   output logic [pinmux_pkg::DATA_W-1:0]      reg_rdata_o,
   output logic                               reg_ack_o,
   output logic [NUM_PADS-1:0]                pad_out_o,
   output logic [NUM_PADS-1:0]                pad_oen_o
);
   import pinmux_pkg::*;

   logic                ack_q;
   logic [DATA_W-1:0]   rdata_q;
   logic [DATA_W-1:0]   rdata_d;
   logic                wr_en;
   logic [DATA_W-1:0]   dir_new;
   logic [DATA_W-1:0]   out_new;
   logic [DATA_W-1:0]   func_new;
   logic [NUM_PADS-1:0] dir_q;
   logic [NUM_PADS-1:0] out_q;
   logic [NUM_PWM-1:0]  func_q;
   logic [NUM_PADS-1:0] in_meta_q;
   logic [NUM_PADS-1:0] in_sync_q;
   logic [NUM_PADS-1:0] func_pad;
   logic [NUM_PADS-1:0] pwm_pad;

   // --------------------------------------------------------------------
   // Bus handshake and register file
   // --------------------------------------------------------------------
   assign wr_en = reg_cs_i & reg_wr_i & ~ack_q;

   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= reg_cs_i & ~ack_q;
      end
   end

   always_ff @(posedge mclk) begin
      if (reg_cs_i && !ack_q) begin
         rdata_q <= rdata_d;
      end
   end

   assign reg_ack_o   = ack_q;
   assign reg_rdata_o = rdata_q;

   // Narrow registers widen with zeros
   assign dir_new  = apply_be(DATA_W'(dir_q), reg_wdata_i, reg_be_i);
   assign out_new  = apply_be(DATA_W'(out_q), reg_wdata_i, reg_be_i);
   assign func_new = apply_be(DATA_W'(func_q), reg_wdata_i, reg_be_i);

   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         dir_q  <= '0;
         out_q  <= '0;
         func_q <= '0;
      end else if (wr_en) begin
         case (reg_ofs_i)
            GPIO_OFS_DIR:  dir_q  <= dir_new[NUM_PADS-1:0];
            GPIO_OFS_OUT:  out_q  <= out_new[NUM_PADS-1:0];
            GPIO_OFS_FUNC: func_q <= func_new[NUM_PWM-1:0];
            default:       ;
         endcase
      end
   end

   // Two flop input synchronizer
   always_ff @(posedge mclk) begin
      in_meta_q <= pad_in_i;
      in_sync_q <= in_meta_q;
   end

   always_comb begin
      rdata_d = '0;
      case (reg_ofs_i)
         GPIO_OFS_DIR:  rdata_d[NUM_PADS-1:0] = dir_q;
         GPIO_OFS_OUT:  rdata_d[NUM_PADS-1:0] = out_q;
         GPIO_OFS_IN:   rdata_d[NUM_PADS-1:0] = in_sync_q;
         GPIO_OFS_FUNC: rdata_d[NUM_PWM-1:0]  = func_q;
         default:       rdata_d = '0;
      endcase
   end

   // --------------------------------------------------------------------
   // Pad multiplexer
   // --------------------------------------------------------------------
   // PWM channels map onto the low pads
   always_comb begin
      func_pad = '0;
      pwm_pad  = '0;
      func_pad[NUM_PWM-1:0] = func_q;
      pwm_pad[NUM_PWM-1:0]  = pwm_wfm_i;
   end

   // Registered pad drive, oen active low
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         pad_out_o <= '0;
         pad_oen_o <= '1;
      end else begin
         pad_out_o <= (func_pad & pwm_pad) | (~func_pad & out_q);
         pad_oen_o <= ~(func_pad | dir_q);
      end
   end

endmodule

`default_nettype wire

//--- logic/pinmux_top.sv
// Peripheral block top level
`timescale 1ns/1ps
`default_nettype none

module pinmux_top #(
   parameter int NUM_PADS   = 16,
   parameter int NUM_PWM    = 4,
   parameter int NUM_TIMERS = 3,
   parameter int TICK_DIV   = 50000
) (
   input  wire logic                          mclk,
   input  wire logic                          rst_n_i,
   input  wire logic                          reg_cs_i,
   input  wire logic                          reg_wr_i,
   input  wire logic [pinmux_pkg::ADDR_W-1:0] reg_addr_i,
   input  wire logic [pinmux_pkg::DATA_W-1:0] reg_wdata_i,
   input  wire logic [pinmux_pkg::BE_W-1:0]   reg_be_i,
   input  wire logic [NUM_PADS-1:0]           pad_in_i,
   output logic [pinmux_pkg::DATA_W-1:0]      reg_rdata_o,
   output logic                               reg_ack_o,
   output logic [NUM_PADS-1:0]                pad_out_o,
   output logic [NUM_PADS-1:0]                pad_oen_o,
   output logic [NUM_TIMERS-1:0]              timer_irq_o
);
   import pinmux_pkg::*;

   logic [OFS_W-1:0]   reg_ofs;
   logic               gpio_cs;
   logic               pwm_cs;
   logic               tmr_cs;
   logic [DATA_W-1:0]  gpio_rdata;
   logic [DATA_W-1:0]  pwm_rdata;
   logic [DATA_W-1:0]  tmr_rdata;
   logic               gpio_ack;
   logic               pwm_ack;
   logic               tmr_ack;
   logic               tick;
   logic [NUM_PWM-1:0] pwm_wfm;

   // Word offset, addr[5:2]
   assign reg_ofs = reg_addr_i[OFS_W+1:2];

   // --------------------------------------------------------------------
   // Decoder and tick
   // --------------------------------------------------------------------
   reg_decode u_decode (
      .reg_cs_i     (reg_cs_i),
      .reg_addr_i   (reg_addr_i),
      .gpio_rdata_i (gpio_rdata),
      .pwm_rdata_i  (pwm_rdata),
      .tmr_rdata_i  (tmr_rdata),
      .gpio_ack_i   (gpio_ack),
      .pwm_ack_i    (pwm_ack),
      .tmr_ack_i    (tmr_ack),
      .gpio_cs_o    (gpio_cs),
      .pwm_cs_o     (pwm_cs),
      .tmr_cs_o     (tmr_cs),
      .reg_rdata_o  (reg_rdata_o),
      .reg_ack_o    (reg_ack_o)
   );

   tick_gen #(.TICK_DIV(TICK_DIV)) u_tick (
      .mclk    (mclk),
      .rst_n_i (rst_n_i),
      .tick_o  (tick)
   );

   // --------------------------------------------------------------------
   // Peripheral blocks
   // --------------------------------------------------------------------
   timer_bank #(.NUM_TIMERS(NUM_TIMERS)) u_timer (
      .mclk        (mclk),
      .rst_n_i     (rst_n_i),
      .reg_cs_i    (tmr_cs),
      .reg_wr_i    (reg_wr_i),
      .reg_ofs_i   (reg_ofs),
      .reg_wdata_i (reg_wdata_i),
      .reg_be_i    (reg_be_i),
      .tick_i      (tick),
      .reg_rdata_o (tmr_rdata),
      .reg_ack_o   (tmr_ack),
      .timer_irq_o (timer_irq_o)
   );

   pwm_bank #(.NUM_PWM(NUM_PWM)) u_pwm (
      .mclk        (mclk),
      .rst_n_i     (rst_n_i),
      .reg_cs_i    (pwm_cs),
      .reg_wr_i    (reg_wr_i),
      .reg_ofs_i   (reg_ofs),
      .reg_wdata_i (reg_wdata_i),
      .reg_be_i    (reg_be_i),
      .reg_rdata_o (pwm_rdata),
      .reg_ack_o   (pwm_ack),
      .pwm_wfm_o   (pwm_wfm)
   );

   // Owns the pads, PWM routed in here
   gpio_pinmux #(
      .NUM_PADS (NUM_PADS),
      .NUM_PWM  (NUM_PWM)
   ) u_gpio (
      .mclk        (mclk),
      .rst_n_i     (rst_n_i),
      .reg_cs_i    (gpio_cs),
      .reg_wr_i    (reg_wr_i),
      .reg_ofs_i   (reg_ofs),
      .reg_wdata_i (reg_wdata_i),
      .reg_be_i    (reg_be_i),
      .pwm_wfm_i   (pwm_wfm),
      .pad_in_i    (pad_in_i),
      .reg_rdata_o (gpio_rdata),
      .reg_ack_o   (gpio_ack),
      .pad_out_o   (pad_out_o),
      .pad_oen_o   (pad_oen_o)
   );

endmodule

`default_nettype wire

//--- testbench/tb_pinmux_top.sv
// Peripheral block testbench
`timescale 1ns/1ps
`default_nettype none

module tb_pinmux_top;
   import pinmux_pkg::*;

   localparam int NUM_PADS   = 16;
   localparam int NUM_TIMERS = 3;
   localparam int MAX_OPS    = 128;
   localparam int ACK_WAIT   = 8;

   logic                  mclk;
   logic                  rst_n_i;
   logic                  reg_cs_i;
   logic                  reg_wr_i;
   logic [ADDR_W-1:0]     reg_addr_i;
   logic [DATA_W-1:0]     reg_wdata_i;
   logic [BE_W-1:0]       reg_be_i;
   logic [NUM_PADS-1:0]   pad_in_i;
   logic [DATA_W-1:0]     reg_rdata_o;
   logic                  reg_ack_o;
   logic [NUM_PADS-1:0]   pad_out_o;
   logic [NUM_PADS-1:0]   pad_oen_o;
   logic [NUM_TIMERS-1:0] timer_irq_o;

   // Golden operations, one entry per file line
   logic [7:0]          g_op   [MAX_OPS];
   logic [31:0]         g_addr [MAX_OPS];
   logic [31:0]         g_data [MAX_OPS];
   logic [BE_W-1:0]     g_be   [MAX_OPS];
   logic [31:0]         g_exp  [MAX_OPS];
   logic [31:0]         g_mask [MAX_OPS];
   int                  num_ops;
   int                  wd_cycles;
   logic                wd_armed;
   logic [NUM_PADS-1:0] pad_pat;
   int                  test_err;
   int                  total_err;
   int                  tests_ok;
   int                  tests_bad;

   pinmux_top #(.TICK_DIV(20)) u_dut (
      .mclk        (mclk),
      .rst_n_i     (rst_n_i),
      .reg_cs_i    (reg_cs_i),
      .reg_wr_i    (reg_wr_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .reg_be_i    (reg_be_i),
      .pad_in_i    (pad_in_i),
      .reg_rdata_o (reg_rdata_o),
      .reg_ack_o   (reg_ack_o),
      .pad_out_o   (pad_out_o),
      .pad_oen_o   (pad_oen_o),
      .timer_irq_o (timer_irq_o)
   );

   // 40 ns clock
   always #20 mclk = ~mclk;

   // ----------------------------------------------------------------------
   // Checking and bus master
   // ----------------------------------------------------------------------
   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp, input logic [31:0] mask);
      assert ((got & mask) == (exp & mask)) else begin
         $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp & mask, got & mask);
         test_err++;
      end
   endtask

   // One access, held until ack or max_wait cycles
   task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                             output logic got_ack, output logic [DATA_W-1:0] rdata);
      int n;
      got_ack = 1'b0;
      rdata   = '0;
      n       = 0;
      @(posedge mclk);
      reg_cs_i    <= 1'b1;
      reg_wr_i    <= wr;
      reg_addr_i  <= addr;
      reg_wdata_i <= wdata;
      reg_be_i    <= be;
      while (!got_ack && n < ACK_WAIT) begin
         // Ack and read data are settled at the falling edge
         @(negedge mclk);
         if (reg_ack_o) begin
            got_ack = 1'b1;
            rdata   = reg_rdata_o;
         end
         n++;
      end
      @(posedge mclk);
      reg_cs_i <= 1'b0;
      reg_wr_i <= 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // Golden file handling
   // ----------------------------------------------------------------------
   task automatic load_golden(output logic ok);
      int          fd;
      int          cnt;
      string       line;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] b;
      logic [31:0] e;
      logic [31:0] m;
      ok      = 1'b0;
      num_ops = 0;
      fd = $fopen("testbench/pinmux_golden.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip column notes and blank lines
            if (line.len() < 2 || line[0] == "#") begin
               continue;
            end
            cnt = $sscanf(line, "%c %h %h %h %h %h", op, a, d, b, e, m);
            if (cnt == 6 && num_ops < MAX_OPS) begin
               g_op[num_ops]   = op;
               g_addr[num_ops] = a;
               g_data[num_ops] = d;
               g_be[num_ops]   = b[BE_W-1:0];
               g_exp[num_ops]  = e;
               g_mask[num_ops] = m;
               num_ops++;
            end
         end
         $fclose(fd);
      end
   endtask

   // Waits and windows count fully, bus operations get 200 cycles each
   function automatic int run_budget();
      int sum;
      sum = 100;
      for (int k = 0; k < num_ops; k++) begin
         case (g_op[k])
            "D": sum += g_addr[k];
            "M": sum += g_data[k];
            "W", "R", "I", "U": sum += 200;
            default: sum += 1;
         endcase
      end
      return sum;
   endfunction

   task automatic run_op(input int k);
      logic              ack;
      logic [DATA_W-1:0] rd;
      int                hi;
      case (g_op[k])
         "W", "R", "I": begin
            bus_access(g_op[k] == "W", g_addr[k][ADDR_W-1:0], g_data[k], g_be[k], ack, rd);
            assert (ack) else begin
               $display("No ack received for access to address %h", g_addr[k]);
               test_err++;
            end
            if (g_op[k] == "R") begin
               check_val("reg_rdata_o", rd, g_exp[k], g_mask[k]);
            end
            // IN register mirrors the last driven pad pattern
            if (g_op[k] == "I") begin
               check_val("reg_rdata_o", rd, DATA_W'(pad_pat), g_mask[k]);
            end
         end
         "U": begin
            bus_access(1'b0, g_addr[k][ADDR_W-1:0], '0, g_be[k], ack, rd);
            assert (!ack) else begin
               $display("Unmapped address %h was acknowledged", g_addr[k]);
               test_err++;
            end
         end
         "D": repeat (g_addr[k]) @(posedge mclk);
         "P": begin
            @(posedge mclk);
            pad_pat = NUM_PADS'($urandom());
            pad_in_i <= pad_pat;
         end
         "C": begin
            @(negedge mclk);
            check_val("pad_out_o", pad_out_o, g_exp[k], g_mask[k]);
            check_val("pad_oen_o", pad_oen_o, g_data[k], g_mask[k]);
         end
         "M": begin
            hi = 0;
            @(negedge mclk);
            check_val("pad_oen_o", pad_oen_o[g_addr[k]], 32'h0, 32'h1);
            // Count high cycles over consecutive falling edges
            repeat (g_data[k]) begin
               if (pad_out_o[g_addr[k]]) begin
                  hi++;
               end
               @(negedge mclk);
            end
            check_val("pad_out_o high cycles", hi, g_exp[k], 32'hffff_ffff);
         end
         "Q": begin
            @(negedge mclk);
            check_val("timer_irq_o", timer_irq_o, g_exp[k], g_mask[k]);
         end
         "E": begin
            if (test_err == 0) begin
               tests_ok++;
               $display("Test %0d finished: ok", g_addr[k]);
            end else begin
               tests_bad++;
               $display("Test %0d finished: %0d errors", g_addr[k], test_err);
            end
            total_err += test_err;
            test_err = 0;
         end
         default: begin
            $display("Unknown operation code in golden line %0d", k);
            test_err++;
         end
      endcase
   endtask

   // ----------------------------------------------------------------------
   // Watchdog and main sequence
   // ----------------------------------------------------------------------
   initial begin
      wait (wd_armed);
      repeat (wd_cycles) @(posedge mclk);
      $display("Watchdog expired before the golden sequence completed");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      logic ok;
      void'($urandom(32'hdaba2496));
      mclk        = 1'b0;
      rst_n_i     = 1'b0;
      reg_cs_i    = 1'b0;
      reg_wr_i    = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      reg_be_i    = '0;
      pad_in_i    = '0;
      pad_pat     = '0;
      wd_armed    = 1'b0;
      test_err    = 0;
      total_err   = 0;
      tests_ok    = 0;
      tests_bad   = 0;
      load_golden(ok);
      if (!ok) begin
         $display("Could not open the golden stimulus file");
         $display("SOME TESTS FAILED");
         $finish;
      end else begin
         wd_cycles = run_budget();
         wd_armed  = 1'b1;
         repeat (16) @(posedge mclk);
         rst_n_i <= 1'b1;
         for (int k = 0; k < num_ops; k++) begin
            run_op(k);
         end
         // Errors after the last test marker still count
         total_err += test_err;
         $display("Tests ok: %0d, tests failed: %0d, errors: %0d",
                  tests_ok, tests_bad, total_err);
         if (total_err == 0 && tests_ok > 0) begin
            $display("ALL TESTS PASSED");
         end else begin
            $display("SOME TESTS FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- testbench/pinmux_golden.txt
# op addr data be expected mask, all hex; D waits addr cycles, M counts pad addr over data cycles
# W write, R read, U unmapped, P random pads, I read IN, C pads (data=oen), Q irq, E end of test
W 040 FFFFFFFF F 0 0
R 040 0 F 0000FFFF FFFFFFFF
W 040 00001234 2 0 0
R 040 0 F 000012FF FFFFFFFF
W 04C FFFFFFFF F 0 0
R 04C 0 F 0000000F FFFFFFFF
W 04C 0 F 0 0
W 080 FFFFFFFF F 0 0
R 080 0 F 0001FFFF FFFFFFFF
W 080 0 F 0 0
W 0C8 0001ABCD 3 0 0
R 0C8 0 F 0000ABCD FFFFFFFF
E 1 0 0 0 0
U 100 0 F 0 0
U 000 0 F 0 0
U 1C0 0 F 0 0
R 040 0 F 000012FF FFFFFFFF
E 2 0 0 0 0
W 040 00000F0F F 0 0
W 044 0000A5A5 F 0 0
D 1 0 0 0 0
C 0 0000F0F0 0 0000A5A5 0000FFFF
P 0 0 0 0 0
D 3 0 0 0 0
I 048 0 F 0 FFFFFFFF
P 0 0 0 0 0
D 4 0 0 0 0
I 048 0 F 0 FFFFFFFF
R 044 0 F 0000A5A5 FFFFFFFF
R 040 0 F 00000F0F FFFFFFFF
E 3 0 0 0 0
W 040 0 F 0 0
W 084 00010703 F 0 0
W 04C 00000002 F 0 0
D 4 0 0 0 0
M 1 8 0 3 0
W 084 00010309 F 0 0
D 4 0 0 0 0
M 1 4 0 4 0
W 084 00000703 F 0 0
D 4 0 0 0 0
M 1 8 0 0 0
E 4 0 0 0 0
W 0C4 00000001 F 0 0
W 0C0 00010003 F 0 0
D 38 0 0 0 0
Q 0 0 0 0 7
R 0D0 0 F 0 7
D 28 0 0 0 0
Q 0 0 0 1 7
R 0D0 0 F 1 7
W 0C0 00000003 F 0 0
W 0D0 00000001 F 0 0
Q 0 0 0 0 7
R 0D0 0 F 0 7
D 64 0 0 0 0
Q 0 0 0 0 7
E 5 0 0 0 0

//--- flist.f
logic/pinmux_pkg.sv
logic/reg_decode.sv
logic/tick_gen.sv
logic/timer_bank.sv
logic/pwm_bank.sv
logic/gpio_pinmux.sv
logic/pinmux_top.sv
testbench/tb_pinmux_top.sv

//--- Bender.yml
package:
  name: pinmux

sources:
  - files:
      - logic/pinmux_pkg.sv
      - logic/reg_decode.sv
      - logic/tick_gen.sv
      - logic/timer_bank.sv
      - logic/pwm_bank.sv
      - logic/gpio_pinmux.sv
      - logic/pinmux_top.sv
  - target: test
    files:
      - testbench/tb_pinmux_top.sv
